// File: Bender.yml
package:
  name: dma_frontend

sources:
  - include_dirs:
      - logic
    files:
      - logic/dma_op_pkg.sv
      - logic/dma_job_pkg.sv
      - logic/dma_job_if.sv
      - logic/transfer_id_gen.sv
      - logic/acc_decoder.sv
      - logic/job_queue.sv
      - logic/nd_sequencer.sv
      - logic/dma_frontend_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/tb_dma_frontend.sv

// File: flist.f
+incdir+logic
logic/dma_op_pkg.sv
logic/dma_job_pkg.sv
logic/dma_job_if.sv
logic/transfer_id_gen.sv
logic/acc_decoder.sv
logic/job_queue.sv
logic/nd_sequencer.sv
logic/dma_frontend_top.sv
testbench/tb_dma_frontend.sv

// File: logic/acc_decoder.sv
/*
  Decodes accelerator instructions and holds the job shadow registers.
  Register writes never stall. DMCPY, DMSTAT and unknown opcodes need the
  one-entry response register and wait while it is occupied.
*/
`include "dma_settings.svh"

module acc_decoder (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         acc_req_valid_i,
    output logic                         acc_req_ready_o,
    input  dma_op_pkg::dma_op_e          acc_req_op_i,
    input  logic [`DMA_REQ_ID_WIDTH-1:0] acc_req_id_i,
    input  logic [`DMA_DATA_WIDTH-1:0]   acc_req_arga_i,
    input  logic [`DMA_DATA_WIDTH-1:0]   acc_req_argb_i,
    output logic                         acc_rsp_valid_o,
    input  logic                         acc_rsp_ready_i,
    output logic [`DMA_REQ_ID_WIDTH-1:0] acc_rsp_id_o,
    output logic [`DMA_DATA_WIDTH-1:0]   acc_rsp_data_o,
    output logic                         acc_rsp_error_o,
    dma_job_if.src                       job_o,
    input  dma_job_pkg::tf_id_t          next_id_i,
    input  dma_job_pkg::tf_id_t          completed_id_i,
    input  logic                         busy_i,
    output logic                         issue_o
);

    // shadow registers
    dma_job_pkg::addr_t src_q, dst_q, src_stride_q, dst_stride_q;
    dma_job_pkg::reps_t reps_q;

    // response slot
    logic                         rsp_valid_q;
    logic [`DMA_REQ_ID_WIDTH-1:0] rsp_id_q;
    logic [`DMA_DATA_WIDTH-1:0]   rsp_data_q;
    logic                         rsp_error_q;

    logic                       slot_free;
    logic                       needs_rsp;
    logic                       rsp_load;
    logic [`DMA_DATA_WIDTH-1:0] rsp_data_d;
    logic                       rsp_error_d;
    dma_op_pkg::dma_cfg_u       cfg;

    assign cfg = acc_req_argb_i[1:0];

    // stays true until a request takes the slot
    assign slot_free = !rsp_valid_q || acc_rsp_ready_i;

    //--------------------------------------------------
    // decode
    //--------------------------------------------------
    always_comb begin
        acc_req_ready_o = 1'b0;
        job_o.valid     = 1'b0;
        needs_rsp       = 1'b0;
        rsp_data_d      = '0;
        rsp_error_d     = 1'b0;
        unique case (acc_req_op_i)
            dma_op_pkg::DMSRC, dma_op_pkg::DMDST,
            dma_op_pkg::DMSTR, dma_op_pkg::DMREP: begin
                acc_req_ready_o = 1'b1;
            end
            dma_op_pkg::DMCPY: begin
                job_o.valid     = acc_req_valid_i && slot_free;
                acc_req_ready_o = slot_free && job_o.ready;
                needs_rsp       = 1'b1;
                rsp_data_d      = next_id_i;
            end
            dma_op_pkg::DMSTAT: begin
                acc_req_ready_o = slot_free;
                needs_rsp       = 1'b1;
                case (cfg.stat.sel)
                    dma_op_pkg::STAT_COMPLETED: rsp_data_d = completed_id_i;
                    dma_op_pkg::STAT_NEXT:      rsp_data_d = next_id_i;
                    dma_op_pkg::STAT_BUSY:      rsp_data_d = {{(`DMA_DATA_WIDTH-1){1'b0}}, busy_i};
                    default:                    rsp_data_d = {{(`DMA_DATA_WIDTH-1){1'b0}}, !job_o.ready};
                endcase
            end
            default: begin
                // unknown opcode, answered with an error
                acc_req_ready_o = slot_free;
                needs_rsp       = 1'b1;
                rsp_error_d     = 1'b1;
            end
        endcase
    end

    // 1D copies always run a single repetition
    assign job_o.job = '{
        src_addr:   src_q,
        dst_addr:   dst_q,
        length:     acc_req_arga_i,
        src_stride: src_stride_q,
        dst_stride: dst_stride_q,
        reps:       cfg.copy.twod ? reps_q : dma_job_pkg::reps_t'(1)
    };

    assign issue_o  = job_o.valid && job_o.ready;
    assign rsp_load = acc_req_valid_i && acc_req_ready_o && needs_rsp;

    always_ff @(posedge clk_i) begin
        if (acc_req_valid_i) begin
            case (acc_req_op_i)
                dma_op_pkg::DMSRC: src_q <= acc_req_arga_i;
                dma_op_pkg::DMDST: dst_q <= acc_req_arga_i;
                dma_op_pkg::DMSTR: begin
                    src_stride_q <= acc_req_arga_i;
                    dst_stride_q <= acc_req_argb_i;
                end
                dma_op_pkg::DMREP: reps_q <= acc_req_arga_i[`DMA_REP_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    //--------------------------------------------------
    // response register
    //--------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (rsp_load) begin
            rsp_valid_q <= 1'b1;
        end else if (acc_rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rsp_load) begin
            rsp_id_q    <= acc_req_id_i;
            rsp_data_q  <= rsp_data_d;
            rsp_error_q <= rsp_error_d;
        end
    end

    assign acc_rsp_valid_o = rsp_valid_q;
    assign acc_rsp_id_o    = rsp_id_q;
    assign acc_rsp_data_o  = rsp_data_q;
    assign acc_rsp_error_o = rsp_error_q;

endmodule

// File: logic/dma_frontend_top.sv
/*
  Single-channel tightly coupled DMA frontend.
  Bursts go out on a valid/ready port; the backend must pulse burst_done_i
  once per burst, in issue order.
*/
`include "dma_settings.svh"

module dma_frontend_top (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    // accelerator request
    input  logic                         acc_req_valid_i,
    output logic                         acc_req_ready_o,
    input  logic [2:0]                   acc_req_op_i,
    input  logic [`DMA_REQ_ID_WIDTH-1:0] acc_req_id_i,
    input  logic [`DMA_DATA_WIDTH-1:0]   acc_req_arga_i,
    input  logic [`DMA_DATA_WIDTH-1:0]   acc_req_argb_i,
    // accelerator response
    output logic                         acc_rsp_valid_o,
    input  logic                         acc_rsp_ready_i,
    output logic [`DMA_REQ_ID_WIDTH-1:0] acc_rsp_id_o,
    output logic [`DMA_DATA_WIDTH-1:0]   acc_rsp_data_o,
    output logic                         acc_rsp_error_o,
    // burst port to the backend
    output logic                         burst_valid_o,
    input  logic                         burst_ready_i,
    output logic [`DMA_ADDR_WIDTH-1:0]   burst_src_o,
    output logic [`DMA_ADDR_WIDTH-1:0]   burst_dst_o,
    output logic [`DMA_ADDR_WIDTH-1:0]   burst_len_o,
    input  logic                         burst_done_i,
    output logic                         busy_o
);

    dma_job_if dec_job ();
    dma_job_if seq_job ();

    logic                 issue;
    logic                 retire;
    dma_job_pkg::tf_id_t  next_id;
    dma_job_pkg::tf_id_t  completed_id;

    acc_decoder i_acc_decoder (
        .clk_i,
        .rst_n_i,
        .acc_req_valid_i,
        .acc_req_ready_o,
        .acc_req_op_i    ( dma_op_pkg::dma_op_e'(acc_req_op_i) ),
        .acc_req_id_i,
        .acc_req_arga_i,
        .acc_req_argb_i,
        .acc_rsp_valid_o,
        .acc_rsp_ready_i,
        .acc_rsp_id_o,
        .acc_rsp_data_o,
        .acc_rsp_error_o,
        .job_o           ( dec_job.src  ),
        .next_id_i       ( next_id      ),
        .completed_id_i  ( completed_id ),
        .busy_i          ( busy_o       ),
        .issue_o         ( issue        )
    );

    job_queue i_job_queue (
        .clk_i,
        .rst_n_i,
        .in_i  ( dec_job.snk ),
        .out_o ( seq_job.src )
    );

    nd_sequencer i_nd_sequencer (
        .clk_i,
        .rst_n_i,
        .job_i    ( seq_job.snk ),
        .burst_valid_o,
        .burst_ready_i,
        .burst_src_o,
        .burst_dst_o,
        .burst_len_o,
        .burst_done_i,
        .retire_o ( retire ),
        .busy_o
    );

    transfer_id_gen i_transfer_id_gen (
        .clk_i,
        .rst_n_i,
        .issue_i        ( issue        ),
        .retire_i       ( retire       ),
        .next_id_o      ( next_id      ),
        .completed_id_o ( completed_id )
    );

endmodule

// File: logic/dma_job_if.sv
/*
  Valid/ready stream of job descriptors.
  A job moves when valid and ready are both high; the source keeps valid
  and the job stable until then.
*/
interface dma_job_if;

    logic              valid;
    logic              ready;
    dma_job_pkg::job_t job;

    // producer side
    modport src (
        output valid,
        output job,
        input  ready
    );

    // consumer side
    modport snk (
        input  valid,
        input  job,
        output ready
    );

endinterface

// File: logic/dma_job_pkg.sv
/*
  Job descriptor passed from the decoder through the queue to the sequencer.
  One job describes up to reps bursts of equal length.
*/
`include "dma_settings.svh"

package dma_job_pkg;

    typedef logic [`DMA_ADDR_WIDTH-1:0]  addr_t;
    typedef logic [`DMA_REP_WIDTH-1:0]   reps_t;
    typedef logic [`DMA_TF_ID_WIDTH-1:0] tf_id_t;

    //--------------------------------------------------
    // job descriptor
    //--------------------------------------------------
    typedef struct packed {
        addr_t src_addr;
        addr_t dst_addr;
        // bytes per burst
        addr_t length;
        addr_t src_stride;
        addr_t dst_stride;
        // 1 for a one-dimensional copy
        reps_t reps;
    } job_t;

endpackage

// File: logic/dma_op_pkg.sv
/*
  Accelerator-side encodings of the DMA frontend.
  Opcodes 6 and 7 are not assigned and are answered with an error.
*/
package dma_op_pkg;

    // accelerator opcode, 3 bits
    typedef enum logic [2:0] {
        DMSRC  = 3'd0,
        DMDST  = 3'd1,
        DMSTR  = 3'd2,
        DMREP  = 3'd3,
        DMCPY  = 3'd4,
        DMSTAT = 3'd5
    } dma_op_e;

    // status word select for DMSTAT
    typedef enum logic [1:0] {
        STAT_COMPLETED = 2'd0,
        STAT_NEXT      = 2'd1,
        STAT_BUSY      = 2'd2,
        STAT_FULL      = 2'd3
    } dma_stat_sel_e;

    //--------------------------------------------------
    // low bits of argb
    //--------------------------------------------------
    typedef struct packed {
        logic twod;
        logic reserved;
    } dma_cfg_copy_t;

    typedef struct packed {
        dma_stat_sel_e sel;
    } dma_cfg_stat_t;

    // DMCPY reads the copy view, DMSTAT the status view
    typedef union packed {
        dma_cfg_copy_t copy;
        dma_cfg_stat_t stat;
    } dma_cfg_u;

endpackage

// File: logic/dma_settings.svh
/*
  Widths and depths shared by the DMA frontend and its testbench.
  Addresses are 32 bits; the data and transfer ID widths must match it.
*/
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// datapath widths
`define DMA_ADDR_WIDTH      32
`define DMA_DATA_WIDTH      32
`define DMA_REP_WIDTH       16
`define DMA_REQ_ID_WIDTH    5
`define DMA_TF_ID_WIDTH     32

// buffering and flow control
`define DMA_JOB_QUEUE_DEPTH 4
`define DMA_MAX_OUTSTANDING 4

`endif

// File: logic/job_queue.sv
/*
  FIFO of job descriptors. A pushed job shows at the output one cycle later.
  Depth must be at least 2. Ready is low while full.
*/
`include "dma_settings.svh"

module job_queue #(
    parameter int unsigned Depth = `DMA_JOB_QUEUE_DEPTH
) (
    input  logic   clk_i,
    input  logic   rst_n_i,
    dma_job_if.snk in_i,
    dma_job_if.src out_o
);

    localparam int unsigned PtrW = $clog2(Depth);
    localparam int unsigned CntW = $clog2(Depth + 1);

    dma_job_pkg::job_t mem_q [Depth];
    logic [PtrW-1:0]   wr_ptr_q, rd_ptr_q;
    logic [CntW-1:0]   cnt_q;
    logic              push, pop;

    assign in_i.ready  = (cnt_q != CntW'(Depth));
    assign out_o.valid = (cnt_q != '0);
    assign out_o.job   = mem_q[rd_ptr_q];

    assign push = in_i.valid && in_i.ready;
    assign pop  = out_o.valid && out_o.ready;

    // pointers and fill count
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (pop && !push) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_i.job;
        end
    end

endmodule

// File: logic/nd_sequencer.sv
/*
  Expands one job at a time into strided bursts.
  Holds back bursts while DMA_MAX_OUTSTANDING are incomplete and retires a
  job on its last completion. Jobs with zero length or zero reps issue nothing.
*/
`include "dma_settings.svh"

module nd_sequencer (
    input  logic               clk_i,
    input  logic               rst_n_i,
    dma_job_if.snk             job_i,
    output logic               burst_valid_o,
    input  logic               burst_ready_i,
    output dma_job_pkg::addr_t burst_src_o,
    output dma_job_pkg::addr_t burst_dst_o,
    output dma_job_pkg::addr_t burst_len_o,
    input  logic               burst_done_i,
    output logic               retire_o,
    output logic               busy_o
);

    localparam int unsigned OutW = $clog2(`DMA_MAX_OUTSTANDING + 1);
    localparam logic [OutW-1:0] OutMax = OutW'(`DMA_MAX_OUTSTANDING);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_DRAIN
    } seq_state_e;

    seq_state_e         state_q, state_d;
    logic [OutW-1:0]    out_cnt_q;
    dma_job_pkg::reps_t left_q;
    dma_job_pkg::addr_t src_q, dst_q, len_q, src_stride_q, dst_stride_q;
    logic               job_take, job_empty, burst_fire, last_done;

    assign job_i.ready = (state_q == SEQ_IDLE);
    assign job_take    = job_i.valid && job_i.ready;
    assign job_empty   = (job_i.job.length == '0) || (job_i.job.reps == '0);

    assign burst_valid_o = (state_q == SEQ_ISSUE) && (out_cnt_q != OutMax);
    assign burst_fire    = burst_valid_o && burst_ready_i;
    assign burst_src_o   = src_q;
    assign burst_dst_o   = dst_q;
    assign burst_len_o   = len_q;

    // nothing in flight, or the last one finishing now
    assign last_done = (out_cnt_q == '0) || ((out_cnt_q == OutW'(1)) && burst_done_i);
    assign retire_o  = (state_q == SEQ_DRAIN) && last_done;
    assign busy_o    = (state_q != SEQ_IDLE) || job_i.valid;

    //--------------------------------------------------
    // FSM
    //--------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            SEQ_IDLE: begin
                if (job_take) begin
                    state_d = job_empty ? SEQ_DRAIN : SEQ_ISSUE;
                end
            end
            SEQ_ISSUE: begin
                if (burst_fire && (left_q == dma_job_pkg::reps_t'(1))) begin
                    state_d = SEQ_DRAIN;
                end
            end
            SEQ_DRAIN: begin
                if (last_done) begin
                    state_d = SEQ_IDLE;
                end
            end
            default: state_d = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= SEQ_IDLE;
            out_cnt_q <= '0;
            left_q    <= '0;
        end else begin
            state_q <= state_d;
            case ({burst_fire, burst_done_i})
                2'b10:   out_cnt_q <= out_cnt_q + 1'b1;
                2'b01:   out_cnt_q <= out_cnt_q - 1'b1;
                default: ;
            endcase
            if (job_take) begin
                left_q <= job_i.job.reps;
            end else if (burst_fire) begin
                left_q <= left_q - 1'b1;
            end
        end
    end

    // running addresses
    always_ff @(posedge clk_i) begin
        if (job_take) begin
            src_q        <= job_i.job.src_addr;
            dst_q        <= job_i.job.dst_addr;
            len_q        <= job_i.job.length;
            src_stride_q <= job_i.job.src_stride;
            dst_stride_q <= job_i.job.dst_stride;
        end else if (burst_fire) begin
            src_q <= src_q + src_stride_q;
            dst_q <= dst_q + dst_stride_q;
        end
    end

endmodule

// File: logic/transfer_id_gen.sv
/*
  Transfer ID counters. Both wrap at the ID width.
  Next starts at 1, completed at 0.
*/
module transfer_id_gen (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                issue_i,
    input  logic                retire_i,
    output dma_job_pkg::tf_id_t next_id_o,
    output dma_job_pkg::tf_id_t completed_id_o
);

    dma_job_pkg::tf_id_t next_q, completed_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            next_q      <= dma_job_pkg::tf_id_t'(1);
            completed_q <= '0;
        end else begin
            // ID handed to the job being pushed
            if (issue_i) begin
                next_q <= next_q + 1'b1;
            end
            // jobs retire in push order
            if (retire_i) begin
                completed_q <= completed_q + 1'b1;
            end
        end
    end

    assign next_id_o      = next_q;
    assign completed_id_o = completed_q;

endmodule

// File: testbench/tb_dma_frontend.sv
/*
  Testbench for the DMA frontend, stopping at the first mismatch.
  The backend model completes bursts in issue order after random delays.
  DMSTAT is only sent while the frontend is idle.
*/
`include "dma_settings.svh"

module tb_dma_frontend;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int AW           = `DMA_ADDR_WIDTH;
    localparam int DW           = `DMA_DATA_WIDTH;
    localparam int IW           = `DMA_REQ_ID_WIDTH;
    localparam int TIMEOUT      = 500;
    localparam int IDLE_TIMEOUT = 2000;

    typedef struct packed {
        logic [AW-1:0] src;
        logic [AW-1:0] dst;
        logic [AW-1:0] len;
    } burst_t;

    typedef struct packed {
        logic [IW-1:0] id;
        logic [DW-1:0] data;
        logic          err;
    } rsp_t;

    logic          clk_i;
    logic          rst_n_i;
    logic          acc_req_valid_i;
    logic          acc_req_ready_o;
    logic [2:0]    acc_req_op_i;
    logic [IW-1:0] acc_req_id_i;
    logic [DW-1:0] acc_req_arga_i;
    logic [DW-1:0] acc_req_argb_i;
    logic          acc_rsp_valid_o;
    logic          acc_rsp_ready_i;
    logic [IW-1:0] acc_rsp_id_o;
    logic [DW-1:0] acc_rsp_data_o;
    logic          acc_rsp_error_o;
    logic          burst_valid_o;
    logic          burst_ready_i;
    logic [AW-1:0] burst_src_o;
    logic [AW-1:0] burst_dst_o;
    logic [AW-1:0] burst_len_o;
    logic          burst_done_i;
    logic          busy_o;

    // expected traffic and model state
    burst_t        exp_bursts[$];
    rsp_t          exp_rsp[$];
    logic [31:0]   data_rng   = 32'd67540;
    // second stream for the backend, so stimulus order stays fixed
    logic [31:0]   bus_rng    = 32'd67540 ^ 32'h0000_beef;
    int            pending    = 0;
    int            done_delay = 0;
    int            copies     = 0;
    logic          hold_rsp   = 1'b0;
    logic [IW-1:0] tag        = '0;
    logic [AW-1:0] sh_src, sh_dst, sh_sstr, sh_dstr;
    logic [15:0]   sh_reps;

    dma_frontend_top i_dma_frontend_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    //--------------------------------------------------
    // helpers
    //--------------------------------------------------
    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] data_rand();
        data_rng = lcg_step(data_rng);
        return data_rng[31:16];
    endfunction

    function automatic logic [15:0] bus_rand();
        bus_rng = lcg_step(bus_rng);
        return bus_rng[31:16];
    endfunction

    // expected bursts of one job, in issue order
    function automatic void expand_job(input logic [AW-1:0] src, input logic [AW-1:0] dst,
                                       input logic [AW-1:0] len, input logic [AW-1:0] sstr,
                                       input logic [AW-1:0] dstr, input int reps);
        burst_t b;
        if (len == '0) begin
            return;
        end
        for (int i = 0; i < reps; i++) begin
            b.src = src + sstr * AW'(i);
            b.dst = dst + dstr * AW'(i);
            b.len = len;
            exp_bursts.push_back(b);
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] got);
        if (got !== expected) begin
            $display("Fail %s expected %h got %h", name, expected, got);
            $display("tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run aborted");
    endtask

    // called and left at 2 ns after a rising edge
    task automatic send_req(input logic [2:0] op, input logic [DW-1:0] arga,
                            input logic [DW-1:0] argb);
        int   cycles;
        rsp_t r;
        cycles          = 0;
        acc_req_valid_i = 1'b1;
        acc_req_op_i    = op;
        acc_req_id_i    = tag;
        acc_req_arga_i  = arga;
        acc_req_argb_i  = argb;
        @(negedge clk_i);
        while (!acc_req_ready_o) begin
            if (cycles == TIMEOUT) begin
                abort_run("timed out waiting for the request to be accepted");
            end else begin
                cycles++;
                @(negedge clk_i);
            end
        end
        // accepted at the coming edge
        r.id   = tag;
        r.data = '0;
        r.err  = 1'b0;
        case (op)
            dma_op_pkg::DMSRC: sh_src = arga;
            dma_op_pkg::DMDST: sh_dst = arga;
            dma_op_pkg::DMSTR: begin
                sh_sstr = arga;
                sh_dstr = argb;
            end
            dma_op_pkg::DMREP: sh_reps = arga[15:0];
            dma_op_pkg::DMCPY: begin
                copies++;
                r.data = DW'(copies);
                exp_rsp.push_back(r);
                expand_job(sh_src, sh_dst, arga, sh_sstr, sh_dstr,
                           argb[1] ? int'(sh_reps) : 1);
            end
            dma_op_pkg::DMSTAT: begin
                // idle here, so busy and full both read 0
                case (argb[1:0])
                    2'd0:    r.data = DW'(copies);
                    2'd1:    r.data = DW'(copies + 1);
                    default: r.data = '0;
                endcase
                exp_rsp.push_back(r);
            end
            default: begin
                r.err = 1'b1;
                exp_rsp.push_back(r);
            end
        endcase
        @(posedge clk_i);
        #2;
        acc_req_valid_i = 1'b0;
        tag             = tag + 1'b1;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(posedge clk_i);
        #1;
        while (busy_o || pending != 0 || exp_bursts.size() != 0 || exp_rsp.size() != 0) begin
            if (cycles == IDLE_TIMEOUT) begin
                abort_run("timed out waiting for all bursts and responses to finish");
            end else begin
                cycles++;
                @(posedge clk_i);
                #1;
            end
        end
        #1;
    endtask

    //--------------------------------------------------
    // backend and response ready
    //--------------------------------------------------
    initial begin
        burst_ready_i   = 1'b0;
        acc_rsp_ready_i = 1'b0;
        burst_done_i    = 1'b0;
        forever begin
            @(posedge clk_i);
            #2;
            burst_ready_i   = (bus_rand() % 4) != 0;
            acc_rsp_ready_i = !hold_rsp && ((bus_rand() % 3) != 0);
            burst_done_i    = 1'b0;
            if (pending > 0) begin
                if (done_delay == 0) begin
                    burst_done_i = 1'b1;
                    pending--;
                    done_delay = bus_rand() % 6;
                end else begin
                    done_delay--;
                end
            end
        end
    end

    // compare bursts and responses at mid cycle
    initial begin
        burst_t b;
        rsp_t   r;
        forever begin
            @(negedge clk_i);
            if (rst_n_i && burst_valid_o && burst_ready_i) begin
                if (exp_bursts.size() == 0) begin
                    abort_run("a burst was issued when none was expected");
                end else begin
                    b = exp_bursts.pop_front();
                    check_value("burst_src_o", b.src, burst_src_o);
                    check_value("burst_dst_o", b.dst, burst_dst_o);
                    check_value("burst_len_o", b.len, burst_len_o);
                    pending++;
                end
            end
            if (rst_n_i && acc_rsp_valid_o && acc_rsp_ready_i) begin
                if (exp_rsp.size() == 0) begin
                    abort_run("a response arrived when none was expected");
                end else begin
                    r = exp_rsp.pop_front();
                    check_value("acc_rsp_id_o", r.id, acc_rsp_id_o);
                    check_value("acc_rsp_data_o", r.data, acc_rsp_data_o);
                    check_value("acc_rsp_error_o", r.err, acc_rsp_error_o);
                end
            end
        end
    end

    //--------------------------------------------------
    // stimulus
    //--------------------------------------------------
    initial begin
        rst_n_i         = 1'b0;
        acc_req_valid_i = 1'b0;
        acc_req_op_i    = '0;
        acc_req_id_i    = '0;
        acc_req_arga_i  = '0;
        acc_req_argb_i  = '0;
        sh_src          = '0;
        sh_dst          = '0;
        sh_sstr         = '0;
        sh_dstr         = '0;
        sh_reps         = '0;
        repeat (8) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        check_value("acc_rsp_valid_o", 32'd0, acc_rsp_valid_o);
        check_value("burst_valid_o", 32'd0, burst_valid_o);
        check_value("busy_o", 32'd0, busy_o);

        // 1D copy ignores reps
        send_req(dma_op_pkg::DMREP, 32'd4, '0);
        send_req(dma_op_pkg::DMSRC, 32'h1000_0000, '0);
        send_req(dma_op_pkg::DMDST, 32'h2000_0000, '0);
        send_req(dma_op_pkg::DMSTR, 32'h40, 32'h80);
        send_req(dma_op_pkg::DMCPY, 32'h20, 32'h0);
        wait_idle();

        // queued random jobs, mostly 2D
        for (int j = 0; j < 6; j++) begin
            send_req(dma_op_pkg::DMSRC, {data_rand(), data_rand()}, '0);
            send_req(dma_op_pkg::DMDST, {data_rand(), data_rand()}, '0);
            send_req(dma_op_pkg::DMSTR, 32'(data_rand()), 32'(data_rand()));
            send_req(dma_op_pkg::DMREP, 32'(data_rand() % 5 + 1), '0);
            send_req(dma_op_pkg::DMCPY, 32'(data_rand() % 256 + 1),
                     (j % 3 == 0) ? 32'h0 : 32'h2);
        end
        wait_idle();

        // responses held back, then released
        send_req(dma_op_pkg::DMREP, 32'd3, '0);
        hold_rsp = 1'b1;
        fork
            begin
                repeat (40) @(posedge clk_i);
                #1;
                hold_rsp = 1'b0;
                #1;
            end
            begin
                send_req(dma_op_pkg::DMCPY, 32'h10, 32'h2);
                send_req(dma_op_pkg::DMCPY, 32'h18, 32'h2);
                send_req(dma_op_pkg::DMCPY, 32'h08, 32'h0);
            end
        join
        wait_idle();

        // unassigned opcodes
        send_req(3'd6, 32'h1234, '0);
        send_req(3'd7, 32'h5678, 32'h3);

        // zero reps retires without a burst
        send_req(dma_op_pkg::DMREP, 32'd0, '0);
        send_req(dma_op_pkg::DMCPY, 32'h40, 32'h2);
        wait_idle();

        for (int s = 0; s < 4; s++) begin
            send_req(dma_op_pkg::DMSTAT, '0, 32'(s));
        end
        wait_idle();

        $display("all tests passed");
        $finish;
    end

endmodule
